// ==== project.f ====
verilog/nand_pkg.sv
verilog/nand_wait_timer.sv
verilog/nand_bus_cycle.sv
verilog/nand_byte_regs.sv
verilog/nand_sequencer.sv
verilog/nand_master.sv
tests/nand_chip_model.sv
tests/tb_nand_master.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the nand controller testbench with verilator, run it, scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_nand_master \
	-o tb_nand_master > build.log 2>&1 &&
./obj_dir/tb_nand_master > sim.log 2>&1 ||
{ cat build.log sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1
exit 0

// ==== tests/nand_chip_model.sv ====
// nand_chip_model: behavioural nand flash answering reset, read id and read status, with a byte log
`default_nettype none

module nand_chip_model (
	input  wire        clk,
	input  wire        nreset,
	input  wire        nand_cle,
	input  wire        nand_ale,
	input  wire        nand_nwe,
	input  wire        nand_nre,
	input  wire        nand_nce,
	input  wire  [7:0] nand_dq_out,
	input  wire [39:0] id_bytes,
	input  wire  [7:0] status_byte,
	output logic [7:0] dq = 8'h00,
	output logic       rnb = 1'b1
);

	// ----------------------------------------------------------
	// byte log, read by the testbench
	// ----------------------------------------------------------
	localparam logic [1:0] LOG_CMD  = 2'd0;
	localparam logic [1:0] LOG_ADDR = 2'd1;
	localparam logic [1:0] LOG_DATA = 2'd2;
	localparam int LOG_DEPTH = 64;

	logic [1:0] log_kind [LOG_DEPTH];
	logic [7:0] log_byte [LOG_DEPTH];
	int         log_count = 0;

	logic       nwe_q = 1'b1;
	logic       nre_q = 1'b1;
	// reads return the status byte after 70h, id bytes otherwise
	logic       status_mode = 1'b0;
	logic [2:0] id_ptr = 3'd0;
	logic [3:0] busy_cnt = 4'd0;
	logic       we_rise;
	logic       re_rise;
	logic [1:0] kind;
	logic [7:0] id_byte;

	// strobe edges seen one clock late, cle/ale/dq are still held then
	assign we_rise = nand_nwe && !nwe_q && !nand_nce;
	assign re_rise = nand_nre && !nre_q && !nand_nce;
	assign kind = nand_cle ? LOG_CMD : (nand_ale ? LOG_ADDR : LOG_DATA);

	always_comb begin
		case (id_ptr)
			3'd0: id_byte = id_bytes[7:0];
			3'd1: id_byte = id_bytes[15:8];
			3'd2: id_byte = id_bytes[23:16];
			3'd3: id_byte = id_bytes[31:24];
			3'd4: id_byte = id_bytes[39:32];
			default: id_byte = 8'h00;
		endcase
	end

	always @(posedge clk) begin
		if (!nreset) begin
			nwe_q       <= 1'b1;
			nre_q       <= 1'b1;
			log_count   <= 0;
			status_mode <= 1'b0;
			id_ptr      <= 3'd0;
			busy_cnt    <= 4'd0;
			rnb         <= 1'b1;
			dq          <= 8'h00;
		end else begin
			nwe_q <= nand_nwe;
			nre_q <= nand_nre;

			// r/b# low for 10 clocks after a reset command
			if (busy_cnt == 4'd1) begin
				busy_cnt <= 4'd0;
				rnb      <= 1'b1;
			end else if (busy_cnt != 4'd0) begin
				busy_cnt <= busy_cnt - 4'd1;
			end

			if (we_rise) begin
				if (log_count < LOG_DEPTH) begin
					log_kind[log_count] <= kind;
					log_byte[log_count] <= nand_dq_out;
					log_count <= log_count + 1;
				end
				if (nand_cle) begin
					case (nand_dq_out)
						8'hff: begin
							busy_cnt    <= 4'd10;
							rnb         <= 1'b0;
							status_mode <= 1'b0;
							id_ptr      <= 3'd0;
						end
						8'h70: status_mode <= 1'b1;
						default: begin
							status_mode <= 1'b0;
							id_ptr      <= 3'd0;
						end
					endcase
				end else if (nand_ale) begin
					// any address restarts the id sequence
					id_ptr <= 3'd0;
				end
			end

			// drive the byte while re# is low
			if (!nand_nre && !nand_nce)
				dq <= status_mode ? status_byte : id_byte;
			if (re_rise && !status_mode && id_ptr != 3'd7)
				id_ptr <= id_ptr + 3'd1;
		end
	end

endmodule

`default_nettype wire

// ==== tests/tb_nand_master.sv ====
// tb_nand_master: clock, reset, command table with expected values, checks, pin monitor, watchdog
`default_nettype none

module tb_nand_master;

	localparam int PERIOD = 4;
	// per command busy limit and per entry watchdog budget, in clocks
	localparam int MAX_WAIT = 100;
	localparam int CLKS_PER_ENTRY = 120;
	localparam logic [7:0] CHIP_STATUS = 8'he0;

	// expected status: wp bit only, chip enabled, chip enabled with range error
	localparam logic [7:0] ST_BASE = 8'h08;
	localparam logic [7:0] ST_EN   = 8'h0c;
	localparam logic [7:0] ST_ERR  = 8'h1c;

	// what each table entry checks
	localparam logic [3:0] CHK_DATA   = 4'b0001;
	localparam logic [3:0] CHK_STATUS = 4'b0010;
	localparam logic [3:0] CHK_LOG    = 4'b0100;
	localparam logic [3:0] CHK_READY  = 4'b1000;

	// log kinds as recorded by the chip model
	localparam logic [1:0] K_CMD  = 2'd0;
	localparam logic [1:0] K_ADDR = 2'd1;
	localparam logic [1:0] K_DATA = 2'd2;

	typedef struct packed {
		logic [5:0] cmd;
		logic [7:0] din;
		logic [7:0] dout;
		logic [7:0] status;
		logic       nce;
		logic [3:0] flags;
		logic [1:0] log_kind;
		logic [7:0] log_byte;
	} entry_t;

	logic        clk;
	logic        nreset;
	logic        activate;
	logic [5:0]  cmd_in;
	logic [7:0]  data_in;
	wire         busy;
	wire  [7:0]  data_out;
	wire         nand_cle;
	wire         nand_ale;
	wire         nand_nwe;
	wire         nand_nre;
	wire         nand_nce;
	wire         nand_nwp;
	wire  [7:0]  nand_dq_out;
	wire         nand_dq_oe;
	wire  [7:0]  nand_dq_in;
	wire         nand_rnb;

	entry_t      cmd_table [$];
	logic [7:0]  id_val [5];
	logic [7:0]  addr_val [5];
	logic [39:0] id_bytes;
	logic [31:0] seed;
	int          n_entries = 0;
	int          errors = 0;
	int          rnb_low_clocks = 0;
	// set once a command never drops busy
	logic        hung = 1'b0;

	nand_master u_dut (
		.clk         (clk),
		.nreset      (nreset),
		.activate    (activate),
		.cmd_in      (cmd_in),
		.data_in     (data_in),
		.busy        (busy),
		.data_out    (data_out),
		.nand_cle    (nand_cle),
		.nand_ale    (nand_ale),
		.nand_nwe    (nand_nwe),
		.nand_nre    (nand_nre),
		.nand_nce    (nand_nce),
		.nand_nwp    (nand_nwp),
		.nand_dq_out (nand_dq_out),
		.nand_dq_oe  (nand_dq_oe),
		.nand_dq_in  (nand_dq_in),
		.nand_rnb    (nand_rnb)
	);

	nand_chip_model u_chip (
		.clk         (clk),
		.nreset      (nreset),
		.nand_cle    (nand_cle),
		.nand_ale    (nand_ale),
		.nand_nwe    (nand_nwe),
		.nand_nre    (nand_nre),
		.nand_nce    (nand_nce),
		.nand_dq_out (nand_dq_out),
		.id_bytes    (id_bytes),
		.status_byte (CHIP_STATUS),
		.dq          (nand_dq_in),
		.rnb         (nand_rnb)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// counts clocks with the chip busy
	always @(posedge clk) begin
		if (nreset && !nand_rnb)
			rnb_low_clocks <= rnb_low_clocks + 1;
	end

	// wp# held low, dq driven through write strobes and released for reads
	always @(posedge clk) begin
		if (nreset) begin
			assert (nand_nwp == 1'b0) else begin
				$display("Mismatch at time %0t: nand_nwp = %0b, expected 0",
					$time, nand_nwp);
				errors++;
			end
			if (nand_cle || nand_ale || !nand_nwe)
				assert (nand_dq_oe == 1'b1) else begin
					$display("Mismatch at time %0t: nand_dq_oe = %0b, expected 1",
						$time, nand_dq_oe);
					errors++;
				end
			if (!nand_nre)
				assert (nand_dq_oe == 1'b0) else begin
					$display("Mismatch at time %0t: nand_dq_oe = %0b, expected 0",
						$time, nand_dq_oe);
					errors++;
				end
		end
	end

	// ----------------------------------------------------------
	// helpers
	// ----------------------------------------------------------
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic add_entry(input logic [5:0] cmd, input logic [7:0] din,
		input logic [7:0] dout, input logic [7:0] status, input logic nce,
		input logic [3:0] flags, input logic [1:0] lk, input logic [7:0] lb);
		entry_t e;
		e.cmd      = cmd;
		e.din      = din;
		e.dout     = dout;
		e.status   = status;
		e.nce      = nce;
		e.flags    = flags;
		e.log_kind = lk;
		e.log_byte = lb;
		cmd_table.push_back(e);
	endtask

	// pulse activate, then wait for busy to fall
	task automatic run_cmd(input logic [5:0] cmd, input logic [7:0] din,
		output logic [7:0] dout);
		int waited;
		waited = 0;
		@(posedge clk);
		#1;
		activate = 1'b1;
		cmd_in   = cmd;
		data_in  = din;
		@(posedge clk);
		#1;
		activate = 1'b0;
		assert (busy) else begin
			$display("busy did not rise one clock after activate at time %0t", $time);
			errors++;
		end
		while (busy && waited < MAX_WAIT) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (busy) begin
			$display("timeout: busy still high %0d clocks after command %0d", waited, cmd);
			errors++;
			hung = 1'b1;
		end
		dout = data_out;
	endtask

	task automatic build_table();
		int i;
		add_entry(nand_pkg::CMD_GET_STATUS, 8'h00, ST_BASE, ST_BASE, 1'b1, CHK_DATA, K_CMD, 8'h00);
		add_entry(nand_pkg::CMD_CHIP_ENABLE, 8'h00, 8'h00, ST_EN, 1'b0, CHK_STATUS, K_CMD, 8'h00);
		add_entry(nand_pkg::CMD_CHIP_DISABLE, 8'h00, 8'h00, ST_BASE, 1'b1, CHK_STATUS, K_CMD, 8'h00);
		add_entry(nand_pkg::CMD_CHIP_ENABLE, 8'h00, 8'h00, ST_EN, 1'b0, CHK_STATUS, K_CMD, 8'h00);
		add_entry(nand_pkg::CMD_NAND_RESET, 8'h00, 8'h00, ST_EN, 1'b0,
			CHK_STATUS | CHK_LOG | CHK_READY, K_CMD, 8'hff);
		add_entry(nand_pkg::CMD_READ_ID, 8'h00, 8'h00, ST_EN, 1'b0,
			CHK_STATUS | CHK_LOG, K_CMD, 8'h90);
		// id bytes by index, then one past the end, then wrap to the first
		add_entry(nand_pkg::CMD_RESET_INDEX, 8'h00, 8'h00, ST_EN, 1'b0, 4'b0000, K_CMD, 8'h00);
		for (i = 0; i < 5; i++)
			add_entry(nand_pkg::CMD_GET_ID_BYTE, 8'h00, id_val[i], ST_EN, 1'b0,
				CHK_DATA | CHK_STATUS, K_CMD, 8'h00);
		add_entry(nand_pkg::CMD_GET_ID_BYTE, 8'h00, 8'h00, ST_ERR, 1'b0,
			CHK_DATA | CHK_STATUS, K_CMD, 8'h00);
		add_entry(nand_pkg::CMD_GET_ID_BYTE, 8'h00, id_val[0], ST_EN, 1'b0,
			CHK_DATA | CHK_STATUS, K_CMD, 8'h00);
		// address bytes written, then read back
		add_entry(nand_pkg::CMD_RESET_INDEX, 8'h00, 8'h00, ST_EN, 1'b0, 4'b0000, K_CMD, 8'h00);
		for (i = 0; i < 5; i++)
			add_entry(nand_pkg::CMD_SET_ADDR_BYTE, addr_val[i], 8'h00, ST_EN, 1'b0,
				CHK_STATUS, K_CMD, 8'h00);
		add_entry(nand_pkg::CMD_RESET_INDEX, 8'h00, 8'h00, ST_EN, 1'b0, 4'b0000, K_CMD, 8'h00);
		for (i = 0; i < 5; i++)
			add_entry(nand_pkg::CMD_GET_ADDR_BYTE, 8'h00, addr_val[i], ST_EN, 1'b0,
				CHK_DATA | CHK_STATUS, K_CMD, 8'h00);
		add_entry(nand_pkg::CMD_GET_ADDR_BYTE, 8'h00, 8'h00, ST_ERR, 1'b0,
			CHK_DATA | CHK_STATUS, K_CMD, 8'h00);
		add_entry(nand_pkg::CMD_READ_STATUS, 8'h00, CHIP_STATUS, ST_ERR, 1'b0,
			CHK_DATA | CHK_LOG, K_CMD, 8'h70);
		// bypass: raw write, then a hand made read id
		add_entry(nand_pkg::CMD_BYPASS_WR, 8'h5a, 8'h00, ST_ERR, 1'b0, CHK_LOG, K_DATA, 8'h5a);
		add_entry(nand_pkg::CMD_BYPASS_CMD, 8'h90, 8'h00, ST_ERR, 1'b0, CHK_LOG, K_CMD, 8'h90);
		add_entry(nand_pkg::CMD_BYPASS_ADDR, 8'h00, 8'h00, ST_ERR, 1'b0, CHK_LOG, K_ADDR, 8'h00);
		add_entry(nand_pkg::CMD_BYPASS_RD, 8'h00, id_val[0], ST_ERR, 1'b0, CHK_DATA, K_CMD, 8'h00);
		add_entry(nand_pkg::CMD_BYPASS_RD, 8'h00, id_val[1], ST_ERR, 1'b0, CHK_DATA, K_CMD, 8'h00);
	endtask

	// ----------------------------------------------------------
	// table loop
	// ----------------------------------------------------------
	initial begin
		entry_t     e;
		logic [7:0] got;
		logic [7:0] st;
		int         i;
		int         errors_before;
		int         log_start;
		int         low_start;
		int         n_pass;
		int         n_fail;
		activate = 1'b0;
		cmd_in   = '0;
		data_in  = '0;
		nreset   = 1'b0;
		n_pass   = 0;
		n_fail   = 0;
		seed     = 32'd99;
		for (i = 0; i < 5; i++) begin
			seed = lcg_next(seed);
			id_val[i] = seed[23:16];
		end
		for (i = 0; i < 5; i++) begin
			seed = lcg_next(seed);
			addr_val[i] = seed[23:16];
		end
		id_bytes = {id_val[4], id_val[3], id_val[2], id_val[1], id_val[0]};
		build_table();
		n_entries = cmd_table.size();

		repeat (2) @(posedge clk);
		#1;
		nreset = 1'b1;

		for (i = 0; i < n_entries && !hung; i++) begin
			e = cmd_table[i];
			errors_before = errors;
			log_start = u_chip.log_count;
			low_start = rnb_low_clocks;
			run_cmd(e.cmd, e.din, got);
			if ((e.flags & CHK_DATA) != 0)
				assert (got == e.dout) else begin
					$display("Mismatch at time %0t: data_out = %02h, expected %02h",
						$time, got, e.dout);
					errors++;
				end
			assert (nand_nce == e.nce) else begin
				$display("Mismatch at time %0t: nand_nce = %0b, expected %0b",
					$time, nand_nce, e.nce);
				errors++;
			end
			if ((e.flags & CHK_READY) != 0)
				assert (rnb_low_clocks > low_start && nand_rnb) else begin
					$display("busy fell without R/B# going low and back high at time %0t", $time);
					errors++;
				end
			if ((e.flags & CHK_LOG) != 0) begin
				assert (u_chip.log_count > log_start) else begin
					$display("the chip model latched no byte for command %0d", e.cmd);
					errors++;
				end
				if (u_chip.log_count > log_start) begin
					assert (u_chip.log_kind[log_start] == e.log_kind) else begin
						$display("Mismatch at time %0t: log kind = %0d, expected %0d",
							$time, u_chip.log_kind[log_start], e.log_kind);
						errors++;
					end
					assert (u_chip.log_byte[log_start] == e.log_byte) else begin
						$display("Mismatch at time %0t: log byte = %02h, expected %02h",
							$time, u_chip.log_byte[log_start], e.log_byte);
						errors++;
					end
				end
			end
			// status is read back through the host interface
			if ((e.flags & CHK_STATUS) != 0 && !hung) begin
				run_cmd(nand_pkg::CMD_GET_STATUS, 8'h00, st);
				assert (st == e.status) else begin
					$display("Mismatch at time %0t: status = %02h, expected %02h",
						$time, st, e.status);
					errors++;
				end
			end
			if (errors == errors_before) begin
				n_pass++;
				$display("test %0d command %0d passed", i, e.cmd);
			end else begin
				n_fail++;
				$display("test %0d command %0d failed", i, e.cmd);
			end
		end

		$display("tests %0d, passed %0d, failed %0d", n_entries, n_pass, n_fail);
		if (n_fail == 0 && errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	// watchdog sized from the table length
	initial begin
		wait (n_entries != 0);
		repeat (n_entries * CLKS_PER_ENTRY + 10) @(posedge clk);
		$display("watchdog: run did not finish within %0d clocks",
			n_entries * CLKS_PER_ENTRY + 10);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/nand_bus_cycle.sv ====
// nand_bus_cycle: one cle, ale, data write or data read strobe cycle on the nand pins
`default_nettype none

module nand_bus_cycle (
	input  wire        clk,
	input  wire        nreset,
	input  wire        cyc_start,
	input  wire nand_pkg::cycle_kind_t cyc_kind,
	input  wire [7:0]  cyc_wdata,
	input  wire [7:0]  nand_dq_in,
	output logic       cyc_done,
	output logic [7:0] cyc_rdata,
	output logic       nand_cle,
	output logic       nand_ale,
	output logic       nand_nwe,
	output logic       nand_nre,
	output logic [7:0] nand_dq_out,
	output logic       nand_dq_oe
);

	localparam int CYC_LEN = nand_pkg::STROBE_LOW + nand_pkg::STROBE_HIGH;
	localparam int PHASE_W = $clog2(CYC_LEN);

	logic active;
	logic [PHASE_W-1:0] phase;
	nand_pkg::cycle_kind_t kind_q;
	logic last_low;

	// last clock of the low phase, strobe rises after it
	assign last_low = active && (phase == PHASE_W'(nand_pkg::STROBE_LOW - 1));

	always_ff @(posedge clk) begin
		if (!nreset) begin
			active     <= 1'b0;
			phase      <= '0;
			kind_q     <= nand_pkg::CYC_CMD;
			cyc_done   <= 1'b0;
			nand_cle   <= 1'b0;
			nand_ale   <= 1'b0;
			nand_nwe   <= 1'b1;
			nand_nre   <= 1'b1;
			nand_dq_oe <= 1'b0;
		end else begin
			cyc_done <= 1'b0;
			if (!active) begin
				if (cyc_start) begin
					active     <= 1'b1;
					phase      <= '0;
					kind_q     <= cyc_kind;
					// latch enables held for the whole cycle
					nand_cle   <= (cyc_kind == nand_pkg::CYC_CMD);
					nand_ale   <= (cyc_kind == nand_pkg::CYC_ADDR);
					// we# low for all write kinds, re# low for reads
					nand_nwe   <= (cyc_kind == nand_pkg::CYC_READ);
					nand_nre   <= (cyc_kind != nand_pkg::CYC_READ);
					nand_dq_oe <= (cyc_kind != nand_pkg::CYC_READ);
				end
			end else begin
				phase <= phase + 1'b1;
				if (last_low) begin
					// rising we# is where the chip latches
					nand_nwe <= 1'b1;
					nand_nre <= 1'b1;
				end
				if (phase == PHASE_W'(CYC_LEN - 2))
					cyc_done <= 1'b1;
				if (phase == PHASE_W'(CYC_LEN - 1)) begin
					active     <= 1'b0;
					nand_cle   <= 1'b0;
					nand_ale   <= 1'b0;
					nand_dq_oe <= 1'b0;
				end
			end
		end
	end

	// write byte and read capture
	always_ff @(posedge clk) begin
		if (cyc_start && !active)
			nand_dq_out <= cyc_wdata;
		if (last_low && kind_q == nand_pkg::CYC_READ)
			cyc_rdata <= nand_dq_in;
	end

endmodule

`default_nettype wire

// ==== verilog/nand_byte_regs.sv ====
// nand_byte_regs: id and address byte storage behind one shared index with range check
`default_nettype none

module nand_byte_regs (
	input  wire        clk,
	input  wire        nreset,
	input  wire        idx_clear,
	input  wire        id_wr,
	input  wire        addr_wr,
	input  wire        id_rd,
	input  wire        addr_rd,
	input  wire  [7:0] wdata,
	output logic [7:0] rdata,
	output logic       range_err
);

	logic [nand_pkg::INDEX_WIDTH-1:0] idx;
	logic [7:0] id_mem [nand_pkg::ID_BYTES];
	logic [7:0] addr_mem [nand_pkg::ADDR_CYCLES];
	logic id_ok;
	logic addr_ok;
	logic access;

	assign id_ok   = idx < nand_pkg::INDEX_WIDTH'(nand_pkg::ID_BYTES);
	assign addr_ok = idx < nand_pkg::INDEX_WIDTH'(nand_pkg::ADDR_CYCLES);
	assign access  = id_wr | id_rd | addr_wr | addr_rd;
	// flagged in the same cycle as the request
	assign range_err = ((id_wr | id_rd) & ~id_ok) | ((addr_wr | addr_rd) & ~addr_ok);

	// 00h out of range
	always_comb begin
		rdata = 8'h00;
		if (id_rd && id_ok)
			rdata = id_mem[idx];
		else if (addr_rd && addr_ok)
			rdata = addr_mem[idx];
	end

	// index steps on each access, wraps to 0 on overrun
	always_ff @(posedge clk) begin
		if (!nreset)
			idx <= '0;
		else if (idx_clear || (access && range_err))
			idx <= '0;
		else if (access)
			idx <= idx + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (id_wr && id_ok)
			id_mem[idx] <= wdata;
		if (addr_wr && addr_ok)
			addr_mem[idx] <= wdata;
	end

endmodule

`default_nettype wire

// ==== verilog/nand_master.sv ====
// nand_master: top level of the nand controller, connects sequencer, bus engine, timer, registers
`default_nettype none

module nand_master (
	input  wire        clk,
	input  wire        nreset,
	// host side
	input  wire        activate,
	input  wire [nand_pkg::CMD_WIDTH-1:0] cmd_in,
	input  wire [7:0]  data_in,
	output logic       busy,
	output logic [7:0] data_out,
	// nand pins, dq pad kept outside
	output logic       nand_cle,
	output logic       nand_ale,
	output logic       nand_nwe,
	output logic       nand_nre,
	output logic       nand_nce,
	output logic       nand_nwp,
	output logic [7:0] nand_dq_out,
	output logic       nand_dq_oe,
	input  wire  [7:0] nand_dq_in,
	input  wire        nand_rnb
);

	// ----------------------------------------------------------
	// internal connections
	// ----------------------------------------------------------
	// bus cycle handshake
	wire       cyc_start;
	wire nand_pkg::cycle_kind_t cyc_kind;
	wire [7:0] cyc_wdata;
	wire       cyc_done;
	wire [7:0] cyc_rdata;

	// delay / ready wait
	wire        wait_start;
	wire [15:0] wait_count;
	wire        wait_done;

	// id and address byte registers
	wire       idx_clear;
	wire       id_wr;
	wire       addr_wr;
	wire       id_rd;
	wire       addr_rd;
	wire [7:0] wdata;
	wire [7:0] rdata;
	wire       range_err;

	// command decode and operation steps
	nand_sequencer u_sequencer (
		.clk        (clk),
		.nreset     (nreset),
		.activate   (activate),
		.cmd_in     (cmd_in),
		.data_in    (data_in),
		.cyc_done   (cyc_done),
		.cyc_rdata  (cyc_rdata),
		.wait_done  (wait_done),
		.rdata      (rdata),
		.range_err  (range_err),
		.busy       (busy),
		.data_out   (data_out),
		.nand_nce   (nand_nce),
		.nand_nwp   (nand_nwp),
		.cyc_start  (cyc_start),
		.cyc_kind   (cyc_kind),
		.cyc_wdata  (cyc_wdata),
		.wait_start (wait_start),
		.wait_count (wait_count),
		.idx_clear  (idx_clear),
		.id_wr      (id_wr),
		.addr_wr    (addr_wr),
		.id_rd      (id_rd),
		.addr_rd    (addr_rd),
		.wdata      (wdata)
	);

	// one strobe cycle on the pins
	nand_bus_cycle u_bus_cycle (
		.clk         (clk),
		.nreset      (nreset),
		.cyc_start   (cyc_start),
		.cyc_kind    (cyc_kind),
		.cyc_wdata   (cyc_wdata),
		.nand_dq_in  (nand_dq_in),
		.cyc_done    (cyc_done),
		.cyc_rdata   (cyc_rdata),
		.nand_cle    (nand_cle),
		.nand_ale    (nand_ale),
		.nand_nwe    (nand_nwe),
		.nand_nre    (nand_nre),
		.nand_dq_out (nand_dq_out),
		.nand_dq_oe  (nand_dq_oe)
	);

	nand_wait_timer u_wait_timer (
		.clk        (clk),
		.nreset     (nreset),
		.wait_start (wait_start),
		.wait_count (wait_count),
		.nand_rnb   (nand_rnb),
		.wait_done  (wait_done)
	);

	nand_byte_regs u_byte_regs (
		.clk       (clk),
		.nreset    (nreset),
		.idx_clear (idx_clear),
		.id_wr     (id_wr),
		.addr_wr   (addr_wr),
		.id_rd     (id_rd),
		.addr_rd   (addr_rd),
		.wdata     (wdata),
		.rdata     (rdata),
		.range_err (range_err)
	);

endmodule

`default_nettype wire

// ==== verilog/nand_pkg.sv ====
// shared constants for the nand controller: host command codes, opcodes, timing, status bits
`default_nettype none

package nand_pkg;

	// ----------------------------------------------------------
	// host command codes
	// ----------------------------------------------------------
	localparam int CMD_WIDTH = 6;

	localparam logic [CMD_WIDTH-1:0] CMD_NAND_RESET    = 6'd1;
	localparam logic [CMD_WIDTH-1:0] CMD_READ_ID       = 6'd3;
	localparam logic [CMD_WIDTH-1:0] CMD_READ_STATUS   = 6'd5;
	localparam logic [CMD_WIDTH-1:0] CMD_GET_STATUS    = 6'd8;
	localparam logic [CMD_WIDTH-1:0] CMD_CHIP_ENABLE   = 6'd9;
	localparam logic [CMD_WIDTH-1:0] CMD_CHIP_DISABLE  = 6'd10;
	localparam logic [CMD_WIDTH-1:0] CMD_RESET_INDEX   = 6'd13;
	localparam logic [CMD_WIDTH-1:0] CMD_GET_ID_BYTE   = 6'd14;
	localparam logic [CMD_WIDTH-1:0] CMD_GET_ADDR_BYTE = 6'd18;
	localparam logic [CMD_WIDTH-1:0] CMD_SET_ADDR_BYTE = 6'd19;
	localparam logic [CMD_WIDTH-1:0] CMD_BYPASS_ADDR   = 6'd20;
	localparam logic [CMD_WIDTH-1:0] CMD_BYPASS_CMD    = 6'd21;
	localparam logic [CMD_WIDTH-1:0] CMD_BYPASS_WR     = 6'd22;
	localparam logic [CMD_WIDTH-1:0] CMD_BYPASS_RD     = 6'd23;

	// onfi opcodes sent on a cle cycle
	localparam logic [7:0] OP_RESET       = 8'hff;
	localparam logic [7:0] OP_READ_ID     = 8'h90;
	localparam logic [7:0] OP_READ_STATUS = 8'h70;

	// ----------------------------------------------------------
	// byte registers and status
	// ----------------------------------------------------------
	localparam int INDEX_WIDTH = 3;
	localparam int ID_BYTES    = 5;
	// fixed, no parameter page to read it from
	localparam int ADDR_CYCLES = 5;

	// write protected from reset on
	localparam logic [7:0] STATUS_RESET = 8'h08;
	localparam int ST_CHIP_EN = 2;
	localparam int ST_WP      = 3;
	localparam int ST_RANGE   = 4;

	// ----------------------------------------------------------
	// bus timing, in clocks
	// ----------------------------------------------------------
	// we# / re# low and high phases of one bus cycle
	localparam int STROBE_LOW  = 2;
	localparam int STROBE_HIGH = 2;

	// we# high to busy, we# high to re# low, ready to re# low
	localparam logic [15:0] T_WB  = 16'd8;
	localparam logic [15:0] T_WHR = 16'd6;
	localparam logic [15:0] T_RR  = 16'd4;

	// role of the byte carried by one bus cycle
	typedef enum logic [1:0] {
		CYC_CMD,
		CYC_ADDR,
		CYC_WRITE,
		CYC_READ
	} cycle_kind_t;

endpackage

`default_nettype wire

// ==== verilog/nand_sequencer.sv ====
// nand_sequencer: host command decode, nand operation steps, status register and ce#
`default_nettype none

module nand_sequencer (
	input  wire        clk,
	input  wire        nreset,
	input  wire        activate,
	input  wire [nand_pkg::CMD_WIDTH-1:0] cmd_in,
	input  wire [7:0]  data_in,
	input  wire        cyc_done,
	input  wire [7:0]  cyc_rdata,
	input  wire        wait_done,
	input  wire [7:0]  rdata,
	input  wire        range_err,
	output logic       busy,
	output logic [7:0] data_out,
	output logic       nand_nce,
	output logic       nand_nwp,
	output logic       cyc_start,
	output nand_pkg::cycle_kind_t cyc_kind,
	output logic [7:0] cyc_wdata,
	output logic       wait_start,
	output logic [15:0] wait_count,
	output logic       idx_clear,
	output logic       id_wr,
	output logic       addr_wr,
	output logic       id_rd,
	output logic       addr_rd,
	output logic [7:0] wdata
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_EXEC,
		S_CYCLE,
		S_WAIT
	} state_t;

	state_t state;
	logic [nand_pkg::CMD_WIDTH-1:0] cmd_q;
	logic [7:0] data_q;
	logic [7:0] status;
	// id bytes read so far during read id
	logic [nand_pkg::INDEX_WIDTH-1:0] id_cnt;
	logic exec;
	logic read_done;

	assign exec = (state == S_EXEC);
	assign read_done = (state == S_CYCLE) && cyc_done && (cyc_kind == nand_pkg::CYC_READ);

	// busy for every state but idle
	assign busy = (state != S_IDLE);
	// wp# follows the fixed write protect bit
	assign nand_nwp = ~status[nand_pkg::ST_WP];

	// ----------------------------------------------------------
	// byte register strobes
	// ----------------------------------------------------------
	// read id restarts the index before filling the id bytes
	assign idx_clear = exec && (cmd_q == nand_pkg::CMD_RESET_INDEX ||
		cmd_q == nand_pkg::CMD_READ_ID);
	assign id_rd   = exec && (cmd_q == nand_pkg::CMD_GET_ID_BYTE);
	assign addr_rd = exec && (cmd_q == nand_pkg::CMD_GET_ADDR_BYTE);
	assign addr_wr = exec && (cmd_q == nand_pkg::CMD_SET_ADDR_BYTE);
	// each id byte goes straight from the bus into the registers
	assign id_wr   = read_done && (cmd_q == nand_pkg::CMD_READ_ID);
	assign wdata   = id_wr ? cyc_rdata : data_q;

	// byte for the next bus cycle, from the command and the cycle kind
	always_comb begin
		case (cmd_q)
			nand_pkg::CMD_NAND_RESET: cyc_wdata = nand_pkg::OP_RESET;
			nand_pkg::CMD_READ_ID: begin
				// single address byte 00h after 90h
				if (cyc_kind == nand_pkg::CYC_ADDR)
					cyc_wdata = 8'h00;
				else
					cyc_wdata = nand_pkg::OP_READ_ID;
			end
			nand_pkg::CMD_READ_STATUS: cyc_wdata = nand_pkg::OP_READ_STATUS;
			// bypass ops carry the host byte
			default: cyc_wdata = data_q;
		endcase
	end

	// ----------------------------------------------------------
	// control fsm
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!nreset) begin
			state      <= S_IDLE;
			cmd_q      <= '0;
			id_cnt     <= '0;
			status     <= nand_pkg::STATUS_RESET;
			nand_nce   <= 1'b1;
			cyc_start  <= 1'b0;
			cyc_kind   <= nand_pkg::CYC_CMD;
			wait_start <= 1'b0;
			wait_count <= '0;
		end else begin
			// start strobes last one clock
			cyc_start  <= 1'b0;
			wait_start <= 1'b0;
			case (state)
				S_IDLE: begin
					if (activate) begin
						cmd_q <= cmd_in;
						state <= S_EXEC;
					end
				end
				S_EXEC: begin
					// register commands finish here
					state <= S_IDLE;
					case (cmd_q)
						nand_pkg::CMD_NAND_RESET, nand_pkg::CMD_READ_ID,
						nand_pkg::CMD_READ_STATUS, nand_pkg::CMD_BYPASS_CMD: begin
							cyc_start <= 1'b1;
							cyc_kind  <= nand_pkg::CYC_CMD;
							id_cnt    <= '0;
							state     <= S_CYCLE;
						end
						nand_pkg::CMD_BYPASS_ADDR: begin
							cyc_start <= 1'b1;
							cyc_kind  <= nand_pkg::CYC_ADDR;
							state     <= S_CYCLE;
						end
						nand_pkg::CMD_BYPASS_WR: begin
							cyc_start <= 1'b1;
							cyc_kind  <= nand_pkg::CYC_WRITE;
							state     <= S_CYCLE;
						end
						nand_pkg::CMD_BYPASS_RD: begin
							cyc_start <= 1'b1;
							cyc_kind  <= nand_pkg::CYC_READ;
							state     <= S_CYCLE;
						end
						nand_pkg::CMD_CHIP_ENABLE: begin
							nand_nce <= 1'b0;
							status[nand_pkg::ST_CHIP_EN] <= 1'b1;
						end
						nand_pkg::CMD_CHIP_DISABLE: begin
							nand_nce <= 1'b1;
							status[nand_pkg::ST_CHIP_EN] <= 1'b0;
						end
						// range flag tracks the last host byte access
						nand_pkg::CMD_GET_ID_BYTE, nand_pkg::CMD_GET_ADDR_BYTE,
						nand_pkg::CMD_SET_ADDR_BYTE: begin
							status[nand_pkg::ST_RANGE] <= range_err;
						end
						default: begin
							// get status, reset index, unknown codes
							state <= S_IDLE;
						end
					endcase
				end
				S_CYCLE: begin
					if (cyc_done) begin
						case (cyc_kind)
							nand_pkg::CYC_CMD: begin
								if (cmd_q == nand_pkg::CMD_READ_ID) begin
									cyc_start <= 1'b1;
									cyc_kind  <= nand_pkg::CYC_ADDR;
								end else begin
									state      <= S_WAIT;
									wait_start <= 1'b1;
									if (cmd_q == nand_pkg::CMD_READ_STATUS)
										wait_count <= nand_pkg::T_WHR;
									else if (cmd_q == nand_pkg::CMD_BYPASS_CMD)
										wait_count <= nand_pkg::T_WB + nand_pkg::T_RR;
									else
										wait_count <= nand_pkg::T_WB;
								end
							end
							nand_pkg::CYC_ADDR: begin
								state      <= S_WAIT;
								wait_start <= 1'b1;
								if (cmd_q == nand_pkg::CMD_BYPASS_ADDR)
									wait_count <= nand_pkg::T_WB + nand_pkg::T_RR;
								else
									wait_count <= nand_pkg::T_WB;
							end
							nand_pkg::CYC_READ: begin
								// read id loops until all id bytes are in
								if (cmd_q == nand_pkg::CMD_READ_ID &&
									id_cnt != nand_pkg::INDEX_WIDTH'(nand_pkg::ID_BYTES - 1)) begin
									id_cnt    <= id_cnt + 1'b1;
									cyc_start <= 1'b1;
								end else begin
									state <= S_IDLE;
								end
							end
							default: state <= S_IDLE;
						endcase
					end
				end
				S_WAIT: begin
					// stalls here while r/b# is low
					if (wait_done) begin
						if (cmd_q == nand_pkg::CMD_READ_ID ||
							cmd_q == nand_pkg::CMD_READ_STATUS) begin
							cyc_start <= 1'b1;
							cyc_kind  <= nand_pkg::CYC_READ;
							state     <= S_CYCLE;
						end else begin
							state <= S_IDLE;
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// ----------------------------------------------------------
	// host data
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (state == S_IDLE && activate)
			data_q <= data_in;
		if (exec && cmd_q == nand_pkg::CMD_GET_STATUS)
			data_out <= status;
		// 00h comes back from the registers when out of range
		if (id_rd || addr_rd)
			data_out <= rdata;
		// read status and bypass read return the bus byte
		if (read_done && cmd_q != nand_pkg::CMD_READ_ID)
			data_out <= cyc_rdata;
	end

endmodule

`default_nettype wire

// ==== verilog/nand_wait_timer.sv ====
// nand_wait_timer: fixed delay countdown followed by a wait for r/b# high
`default_nettype none

module nand_wait_timer (
	input  wire        clk,
	input  wire        nreset,
	input  wire        wait_start,
	input  wire [15:0] wait_count,
	input  wire        nand_rnb,
	output logic       wait_done
);

	// r/b# comes from the chip pad, two flop sync
	logic [1:0]  rnb_sync;
	logic        running;
	logic [15:0] remain;

	always_ff @(posedge clk) begin
		if (!nreset) begin
			rnb_sync  <= 2'b00;
			running   <= 1'b0;
			remain    <= '0;
			wait_done <= 1'b0;
		end else begin
			rnb_sync  <= {rnb_sync[0], nand_rnb};
			wait_done <= 1'b0;
			if (wait_start) begin
				running <= 1'b1;
				remain  <= wait_count;
			end else if (running) begin
				if (remain != '0)
					remain <= remain - 1'b1;
				// count expired, hold until the chip is ready
				else if (rnb_sync[1]) begin
					running   <= 1'b0;
					wait_done <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire
